// ==== verilog/fdc_pkg.sv ====
`default_nettype none

package fdc_pkg;

	//////////////////////////////////////////////////
	// Bus and memory widths

	typedef logic [7:0] byte_t;				// One MCU bus byte

	localparam int SRAM_ADDR_W = 19;		// 512K x 8 SRAM

	//////////////////////////////////////////////////
	// Register map, low address byte only

	typedef enum logic [7:0] {
		REG_ADDR_LOW		= 8'h00,		// SRAM address 7..0
		REG_ADDR_HIGH		= 8'h01,		// SRAM address 15..8
		REG_ADDR_UPPER		= 8'h02,		// SRAM address top bits
		REG_SRAM_DATA		= 8'h03,		// SRAM data port
		REG_DRIVE_CONTROL	= 8'h04,		// Drive control on write, type low on read
		REG_MCO_TYPE_H		= 8'h05,
		REG_MCO_VER_L		= 8'h06,
		REG_MCO_VER_H		= 8'h07,
		REG_STATUS2			= 8'h0F,		// Drive and memory status
		REG_SCRATCH			= 8'h30,		// Bus test scratchpad
		REG_SCRATCH_INV		= 8'h31,
		REG_FIXED_55		= 8'h32,
		REG_FIXED_AA		= 8'h33,
		REG_STEP_RATE		= 8'hF0,		// Step period in timebase ticks
		REG_STEP_CMD		= 8'hFF			// Direction and step count
	} reg_addr_e;

	// Microcode identity, read back by the MCU
	localparam logic [15:0] MCO_TYPE	= 16'hDD55;
	localparam logic [15:0] MCO_VERSION	= 16'h001A;

	//////////////////////////////////////////////////
	// Step command layout

	localparam int STEP_DIR_BIT = 7;		// 1 = inward, 0 = out toward track 0
	localparam int STEP_COUNT_W = 7;		// Step count in bits 6..0

	// 250us timebase at 80MHz
	localparam int TICK_CYCLES_DEFAULT = 20000;

endpackage

`default_nettype wire

// ==== verilog/mcu_register_file.sv ====
`default_nettype none

module mcu_register_file import fdc_pkg::*; #(
	parameter int ADDR_W = SRAM_ADDR_W
) (
	input  wire					CLK_MASTER,
	input  wire					rst,
	input  wire					mcu_pmall,			// Address latch strobe
	input  wire					mcu_pmwr,
	input  wire					mcu_pmrd,
	input  byte_t				mcu_pmd_in,
	output byte_t				mcu_pmd_out,
	output logic				mcu_pmd_oe,
	input  byte_t				sram_dq_in,
	input  wire [ADDR_W-1:0]	sram_a,
	input  wire					addr_empty,
	input  wire					addr_full,
	input  wire					stepping,
	input  wire					fd_index_in,
	input  wire					fd_track0_in,
	input  wire					fd_wrprot_in,
	input  wire					fd_rdy_dchg_in,
	input  wire					fd_dens_in,
	output logic				addr_load_low,
	output logic				addr_load_high,
	output logic				addr_load_upper,
	output byte_t				load_data,
	output logic				addr_inc_read,
	output logic				sram_write_start,
	output byte_t				wr_data,
	output byte_t				step_rate,
	output logic				step_cmd_load,
	output byte_t				step_cmd,
	output logic				fd_dens_out,
	output logic				fd_inuse,
	output logic [3:0]			fd_drvsel,
	output logic				fd_moten,
	output logic				fd_sidesel
);

	byte_t			addr_q;				// Latched register address
	byte_t			drive_ctrl;
	byte_t			scratch;
	byte_t			dq_lat;				// SRAM read latch
	logic			pmwr_s, pmwr_d;
	logic			pmrd_s, pmrd_d;
	logic			wr_pulse;			// One cycle per write strobe
	logic [23:0]	addr_ext;

	//////////////////////////////////////////////////
	// Address latch and strobe edges

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			addr_q		<= '0;
			pmwr_s		<= 1'b0;
			pmwr_d		<= 1'b0;
			pmrd_s		<= 1'b0;
			pmrd_d		<= 1'b0;
			wr_pulse	<= 1'b0;
			addr_inc_read <= 1'b0;
		end else begin
			if (mcu_pmall) begin
				addr_q <= mcu_pmd_in;		// High address byte never decoded
			end
			pmwr_s		<= mcu_pmwr;
			pmwr_d		<= pmwr_s;
			pmrd_s		<= mcu_pmrd;
			pmrd_d		<= pmrd_s;
			wr_pulse	<= pmwr_s && !pmwr_d;	// Rising edge of PMWR
			// End of an SRAM data read bumps the address
			addr_inc_read <= !pmrd_s && pmrd_d && (addr_q == REG_SRAM_DATA);
		end
	end

	// Track the SRAM bus until the MCU starts a read
	always_ff @(posedge CLK_MASTER) begin
		if (!mcu_pmrd) begin
			dq_lat <= sram_dq_in;
		end
	end

	//////////////////////////////////////////////////
	// Register writes

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			drive_ctrl	<= '0;
			scratch		<= '0;
			step_rate	<= '0;
		end else if (wr_pulse) begin
			case (addr_q)
				REG_DRIVE_CONTROL:	drive_ctrl	<= mcu_pmd_in;
				REG_SCRATCH:		scratch		<= mcu_pmd_in;
				REG_STEP_RATE:		step_rate	<= mcu_pmd_in;
				default: ;							// Others handled by strobes below
			endcase
		end
	end

	// Strobes to the datapath, data rides along from the bus
	assign addr_load_low	= wr_pulse && (addr_q == REG_ADDR_LOW);
	assign addr_load_high	= wr_pulse && (addr_q == REG_ADDR_HIGH);
	assign addr_load_upper	= wr_pulse && (addr_q == REG_ADDR_UPPER);
	assign sram_write_start	= wr_pulse && (addr_q == REG_SRAM_DATA);
	assign step_cmd_load	= wr_pulse && (addr_q == REG_STEP_CMD);
	assign load_data		= mcu_pmd_in;
	assign wr_data			= mcu_pmd_in;
	assign step_cmd			= mcu_pmd_in;

	// Drive lines are active low
	assign fd_dens_out	= ~drive_ctrl[0];
	assign fd_inuse		= ~drive_ctrl[1];
	assign fd_drvsel	= ~drive_ctrl[5:2];
	assign fd_moten		= ~drive_ctrl[6];
	assign fd_sidesel	= ~drive_ctrl[7];

	//////////////////////////////////////////////////
	// Readback mux

	assign addr_ext		= 24'(sram_a);		// Unused top bits read 0
	assign mcu_pmd_oe	= mcu_pmrd;

	always_comb begin
		case (addr_q)
			REG_ADDR_LOW:		mcu_pmd_out = addr_ext[7:0];
			REG_ADDR_HIGH:		mcu_pmd_out = addr_ext[15:8];
			REG_ADDR_UPPER:		mcu_pmd_out = addr_ext[23:16];
			REG_SRAM_DATA:		mcu_pmd_out = dq_lat;
			REG_DRIVE_CONTROL:	mcu_pmd_out = MCO_TYPE[7:0];
			REG_MCO_TYPE_H:		mcu_pmd_out = MCO_TYPE[15:8];
			REG_MCO_VER_L:		mcu_pmd_out = MCO_VERSION[7:0];
			REG_MCO_VER_H:		mcu_pmd_out = MCO_VERSION[15:8];
			REG_STATUS2:		mcu_pmd_out = {fd_index_in, fd_track0_in, fd_wrprot_in,
									fd_rdy_dchg_in, fd_dens_in, stepping, addr_empty, addr_full};
			REG_SCRATCH:		mcu_pmd_out = scratch;
			REG_SCRATCH_INV:	mcu_pmd_out = ~scratch;
			REG_FIXED_55:		mcu_pmd_out = 8'h55;
			REG_FIXED_AA:		mcu_pmd_out = 8'hAA;
			default:			mcu_pmd_out = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/sram_address_counter.sv ====
`default_nettype none

module sram_address_counter import fdc_pkg::*; #(
	parameter int ADDR_W = SRAM_ADDR_W
) (
	input  wire					CLK_MASTER,
	input  wire					rst,
	input  byte_t				load_data,
	input  wire					addr_load_low,
	input  wire					addr_load_high,
	input  wire					addr_load_upper,
	input  wire					addr_inc_write,		// From the write sequencer
	input  wire					addr_inc_read,		// From an MCU data read
	output logic [ADDR_W-1:0]	sram_a,
	output logic				addr_empty,
	output logic				addr_full
);

	logic	any_load;
	logic	any_inc;

	assign any_load	= addr_load_low || addr_load_high || addr_load_upper;
	assign any_inc	= addr_inc_write || addr_inc_read;

	// Bytewise load wins over increment
	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			sram_a <= '0;
		end else if (any_load) begin
			if (addr_load_low) begin
				sram_a[7:0] <= load_data;
			end
			if (addr_load_high) begin
				sram_a[15:8] <= load_data;
			end
			if (addr_load_upper) begin
				sram_a[ADDR_W-1:16] <= load_data[ADDR_W-17:0];	// Top bits dropped
			end
		end else if (any_inc && !addr_full) begin
			sram_a <= sram_a + ADDR_W'(1);		// Saturates at all ones
		end
	end

	// Flags
	assign addr_empty	= (sram_a == '0);
	assign addr_full	= &sram_a;

endmodule

`default_nettype wire

// ==== verilog/sram_write_sequencer.sv ====
`default_nettype none

module sram_write_sequencer import fdc_pkg::*; (
	input  wire		CLK_MASTER,
	input  wire		rst,
	input  wire		sram_write_start,
	input  byte_t	wr_data,
	output byte_t	sram_dq_out,
	output logic	sram_we_n,
	output logic	sram_oe_n,
	output logic	addr_inc_write
);

	typedef enum logic [2:0] {
		S_IDLE,			// OE active, waiting for a write
		S_OE_OFF,		// Release the SRAM outputs
		S_WRITE,		// WE low
		S_WRITE_END,	// WE back high, data still driven
		S_INC			// Bump the address
	} state_e;

	state_e	state;

	// Registered outputs so the SRAM pins stay clean
	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			state			<= S_IDLE;
			sram_we_n		<= 1'b1;
			sram_oe_n		<= 1'b0;
			addr_inc_write	<= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					addr_inc_write <= 1'b0;
					if (sram_write_start) begin		// Starts while busy are lost
						sram_oe_n	<= 1'b1;
						state		<= S_OE_OFF;
					end
				end
				S_OE_OFF: begin
					sram_we_n	<= 1'b0;
					state		<= S_WRITE;
				end
				S_WRITE: begin
					sram_we_n	<= 1'b1;			// SRAM latches on this edge
					state		<= S_WRITE_END;
				end
				S_WRITE_END: begin
					sram_oe_n		<= 1'b0;
					addr_inc_write	<= 1'b1;
					state			<= S_INC;
				end
				S_INC: begin
					addr_inc_write	<= 1'b0;
					state			<= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Capture the byte as the sequence starts
	always_ff @(posedge CLK_MASTER) begin
		if ((state == S_IDLE) && sram_write_start) begin
			sram_dq_out <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/head_stepper.sv ====
`default_nettype none

module head_stepper import fdc_pkg::*; #(
	parameter int TICK_CYCLES = TICK_CYCLES_DEFAULT
) (
	input  wire		CLK_MASTER,
	input  wire		rst,
	input  byte_t	step_rate,			// Ticks per step clock half period, minus one
	input  wire		step_cmd_load,
	input  byte_t	step_cmd,
	input  wire		fd_track0_in,		// Active low
	output logic	fd_step,
	output logic	fd_dir,
	output logic	stepping
);

	localparam int TICK_W = $clog2(TICK_CYCLES);

	logic [TICK_W-1:0]			tick_cnt;
	logic						tick;
	byte_t						rate_cnt;
	logic						step_clk;
	logic						step_clk_d;
	logic						step_rise;
	logic						step_fall;
	logic [STEP_COUNT_W-1:0]	remaining;		// Steps still to issue
	logic						at_track0;

	//////////////////////////////////////////////////
	// Timebase and step rate divider

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			tick_cnt	<= '0;
			rate_cnt	<= '0;
			step_clk	<= 1'b0;
			step_clk_d	<= 1'b0;
		end else begin
			tick_cnt	<= tick ? '0 : tick_cnt + TICK_W'(1);
			step_clk_d	<= step_clk;
			if (tick) begin
				if (rate_cnt >= step_rate) begin	// Also catches a rate lowered mid count
					rate_cnt	<= '0;
					step_clk	<= ~step_clk;
				end else begin
					rate_cnt	<= rate_cnt + 8'd1;
				end
			end
		end
	end

	assign step_rise = step_clk && !step_clk_d;
	assign step_fall = !step_clk && step_clk_d;

	//////////////////////////////////////////////////
	// Step controller

	assign at_track0 = !fd_dir && !fd_track0_in;	// Outward and already home

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			remaining	<= '0;
			fd_dir		<= 1'b0;
			fd_step		<= 1'b0;
			stepping	<= 1'b0;
		end else begin
			if (step_cmd_load) begin			// New command replaces the old one
				fd_dir		<= step_cmd[STEP_DIR_BIT];
				remaining	<= step_cmd[STEP_COUNT_W-1:0];
				stepping	<= 1'b1;
			end else if (at_track0) begin
				remaining	<= '0;				// Abort the rest of the move
			end else if (step_rise && (remaining != '0)) begin
				fd_step		<= 1'b1;			// Pulse for this high phase
				remaining	<= remaining - STEP_COUNT_W'(1);
			end

			if (step_fall) begin
				fd_step <= 1'b0;
			end

			// Done once the count is used up and the last pulse is over
			if (!step_cmd_load && stepping && (remaining == '0) && !fd_step) begin
				stepping <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fdc_top.sv ====
`default_nettype none

module fdc_top import fdc_pkg::*; #(
	parameter int ADDR_W		= SRAM_ADDR_W,
	parameter int TICK_CYCLES	= TICK_CYCLES_DEFAULT
) (
	input  wire					CLK_MASTER,
	input  wire					rst,
	// MCU bus
	input  wire					mcu_pmall,
	input  wire					mcu_pmwr,
	input  wire					mcu_pmrd,
	input  byte_t				mcu_pmd_in,
	output byte_t				mcu_pmd_out,
	output logic				mcu_pmd_oe,
	// SRAM
	output logic [ADDR_W-1:0]	sram_a,
	input  byte_t				sram_dq_in,
	output byte_t				sram_dq_out,		// Driven while sram_oe_n is high
	output logic				sram_we_n,
	output logic				sram_oe_n,
	// Drive
	input  wire					fd_index_in,
	input  wire					fd_track0_in,
	input  wire					fd_wrprot_in,
	input  wire					fd_rdy_dchg_in,
	input  wire					fd_dens_in,
	output logic				fd_dens_out,
	output logic				fd_inuse,
	output logic [3:0]			fd_drvsel,
	output logic				fd_moten,
	output logic				fd_sidesel,
	output logic				fd_dir,
	output logic				fd_step
);

	byte_t	load_data;
	logic	addr_load_low, addr_load_high, addr_load_upper;
	logic	addr_inc_read, addr_inc_write;
	logic	addr_empty, addr_full;
	logic	sram_write_start;
	byte_t	wr_data;
	byte_t	step_rate;
	logic	step_cmd_load;
	byte_t	step_cmd;
	logic	stepping;

	//////////////////////////////////////////////////
	// MCU side

	mcu_register_file #(.ADDR_W(ADDR_W)) i_mcu_register_file (
		.CLK_MASTER, .rst,
		.mcu_pmall, .mcu_pmwr, .mcu_pmrd, .mcu_pmd_in, .mcu_pmd_out, .mcu_pmd_oe,
		.sram_dq_in, .sram_a, .addr_empty, .addr_full, .stepping,
		.fd_index_in, .fd_track0_in, .fd_wrprot_in, .fd_rdy_dchg_in, .fd_dens_in,
		.addr_load_low, .addr_load_high, .addr_load_upper, .load_data,
		.addr_inc_read, .sram_write_start, .wr_data,
		.step_rate, .step_cmd_load, .step_cmd,
		.fd_dens_out, .fd_inuse, .fd_drvsel, .fd_moten, .fd_sidesel
	);

	//////////////////////////////////////////////////
	// SRAM path

	sram_address_counter #(.ADDR_W(ADDR_W)) i_sram_address_counter (
		.CLK_MASTER, .rst, .load_data,
		.addr_load_low, .addr_load_high, .addr_load_upper,
		.addr_inc_write, .addr_inc_read,
		.sram_a, .addr_empty, .addr_full
	);

	sram_write_sequencer i_sram_write_sequencer (
		.CLK_MASTER, .rst, .sram_write_start, .wr_data,
		.sram_dq_out, .sram_we_n, .sram_oe_n, .addr_inc_write
	);

	// Head positioning
	head_stepper #(.TICK_CYCLES(TICK_CYCLES)) i_head_stepper (
		.CLK_MASTER, .rst, .step_rate, .step_cmd_load, .step_cmd,
		.fd_track0_in, .fd_step, .fd_dir, .stepping
	);

endmodule

`default_nettype wire

// ==== verification/fdc_asserts.sv ====
`default_nettype none

module fdc_asserts (
	input wire			CLK_MASTER,
	input wire			rst,
	input wire			mcu_pmrd,
	input wire			mcu_pmd_oe,
	input wire			sram_we_n,
	input wire			sram_oe_n,
	input wire [7:0]	sram_dq_out,
	input wire			addr_inc_write,
	input wire			fd_step,
	input wire			stepping,
	input wire [3:0]	fd_drvsel
);

	int unsigned fail_count = 0;		// Failed property count

	//////////////////////////////////////////////////
	// SRAM write timing

	a_we_single: assert property (@(posedge CLK_MASTER) disable iff (rst)
		!sram_we_n |=> sram_we_n)
		else begin
			$error("WE low for more than one cycle");
			fail_count++;
		end
	a_we_inside_oe: assert property (@(posedge CLK_MASTER) disable iff (rst)
		!sram_we_n |-> ($past(sram_oe_n) && sram_oe_n) ##1 sram_oe_n)
		else begin
			$error("WE low outside the OE high window");
			fail_count++;
		end
	a_oe_length: assert property (@(posedge CLK_MASTER) disable iff (rst)
		$rose(sram_oe_n) |=> sram_oe_n ##1 sram_oe_n ##1 !sram_oe_n)
		else begin
			$error("OE high window not three cycles");
			fail_count++;
		end
	a_inc_with_oe: assert property (@(posedge CLK_MASTER) disable iff (rst)
		$fell(sram_oe_n) |-> addr_inc_write ##1 !addr_inc_write)
		else begin
			$error("Address increment not a single pulse at OE low");
			fail_count++;
		end
	a_dq_hold: assert property (@(posedge CLK_MASTER) disable iff (rst)
		(sram_oe_n && $past(sram_oe_n)) |-> $stable(sram_dq_out))
		else begin
			$error("Write data moved while driven");
			fail_count++;
		end

	// Bus and stepper
	a_pmd_oe: assert property (@(posedge CLK_MASTER) disable iff (rst) mcu_pmd_oe == mcu_pmrd)
		else begin
			$error("Data bus enable does not follow PMRD");
			fail_count++;
		end
	a_step_in_move: assert property (@(posedge CLK_MASTER) disable iff (rst) fd_step |-> stepping)
		else begin
			$error("Step pulse outside a move");
			fail_count++;
		end
	a_reset_state: assert property (@(posedge CLK_MASTER)
		rst |=> sram_we_n && !sram_oe_n && !fd_step && !stepping && (fd_drvsel == 4'hF))
		else begin
			$error("Outputs not at reset values");
			fail_count++;
		end

endmodule

bind fdc_top fdc_asserts i_fdc_asserts (.*);

`default_nettype wire

// ==== verification/fdc_tb.sv ====
`default_nettype none

module fdc_tb import fdc_pkg::*; ();

	localparam int CLK_PERIOD		= 10;
	localparam int TICK_CYCLES		= 8;
	localparam int STEP_RATE		= 1;		// Two ticks per step clock half period
	localparam int MAX_STEPS		= 16;
	localparam int STEP_PERIOD		= 2 * (STEP_RATE + 1) * TICK_CYCLES;
	localparam int NUM_OPS			= 64;		// Bus operations with margin
	localparam int WATCHDOG_CYCLES	= NUM_OPS * MAX_STEPS * STEP_PERIOD;

	logic CLK_MASTER, rst;
	logic mcu_pmall, mcu_pmwr, mcu_pmrd, mcu_pmd_oe;
	byte_t mcu_pmd_in, mcu_pmd_out, sram_dq_in, sram_dq_out;
	logic [SRAM_ADDR_W-1:0] sram_a;
	logic sram_we_n, sram_oe_n;
	logic fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in;
	logic fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_dir, fd_step;
	logic [3:0] fd_drvsel;

	byte_t sram_mem [0:(1 << SRAM_ADDR_W)-1];		// External SRAM model
	logic [31:0] lfsr = 32'hd94a8597;
	int mismatches = 0;
	int failures = 0;							// Timeouts and other faults
	int we_low_cycles = 0;
	int step_pulses = 0;
	logic step_d = 1'b0;

	fdc_top #(.ADDR_W(SRAM_ADDR_W), .TICK_CYCLES(TICK_CYCLES)) i_fdc_top (.*);

	always #(CLK_PERIOD / 2) CLK_MASTER = ~CLK_MASTER;

	//////////////////////////////////////////////////
	// SRAM and drive models

	assign sram_dq_in = sram_mem[sram_a];		// Async read

	always @(posedge sram_we_n) begin
		if (!rst) begin
			sram_mem[sram_a] <= sram_dq_out;	// Latch at end of WE
		end
	end

	// Count WE low cycles and step pulses
	always @(posedge CLK_MASTER) begin
		step_d <= fd_step;
		if (fd_step && !step_d) step_pulses <= step_pulses + 1;
		if (sram_we_n === 1'b0) we_low_cycles <= we_low_cycles + 1;
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s read %0h, expected %0h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic set_address(input byte_t a);
		@(posedge CLK_MASTER);
		mcu_pmall	<= 1'b1;
		mcu_pmd_in	<= a;
		@(posedge CLK_MASTER);
		mcu_pmall	<= 1'b0;						// Latched on this edge
	endtask

	task automatic bus_write(input byte_t a, input byte_t d);
		set_address(a);
		mcu_pmd_in	<= d;
		mcu_pmwr	<= 1'b1;
		repeat (4) @(posedge CLK_MASTER);
		mcu_pmwr	<= 1'b0;
		repeat (4) @(posedge CLK_MASTER);			// Bus recovery
	endtask

	task automatic bus_read(input byte_t a, output byte_t d);
		set_address(a);
		mcu_pmrd <= 1'b1;
		repeat (2) @(posedge CLK_MASTER);
		d = mcu_pmd_out;
		mcu_pmrd <= 1'b0;							// Falling edge may bump the address
		repeat (4) @(posedge CLK_MASTER);
	endtask

	task automatic read_check(input byte_t a, input byte_t exp, input string what);
		byte_t rd;
		bus_read(a, rd);
		check(rd, exp, what);
	endtask

	task automatic load_address(input logic [SRAM_ADDR_W-1:0] a, input logic [4:0] pad);
		bus_write(REG_ADDR_LOW, a[7:0]);
		bus_write(REG_ADDR_HIGH, a[15:8]);
		bus_write(REG_ADDR_UPPER, {pad, a[18:16]});	// Pad bits are not stored
	endtask

	task automatic check_address(input logic [SRAM_ADDR_W-1:0] exp, input string what);
		read_check(REG_ADDR_LOW, exp[7:0], {what, " low"});
		read_check(REG_ADDR_HIGH, exp[15:8], {what, " high"});
		read_check(REG_ADDR_UPPER, {5'b0, exp[18:16]}, {what, " upper"});
	endtask

	task automatic wait_step_done();
		int cycles;
		cycles = 0;
		while (stepping_now() && cycles < (MAX_STEPS + 2) * STEP_PERIOD) begin
			@(posedge CLK_MASTER);
			cycles++;
		end
		if (stepping_now()) begin
			$display("Head stepping did not finish within %0d cycles", cycles);
			failures++;
		end
	endtask

	function automatic logic stepping_now();
		return i_fdc_top.stepping;
	endfunction

	//////////////////////////////////////////////////
	// Watchdog

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		byte_t d;
		byte_t rd;
		logic [SRAM_ADDR_W-1:0] exp_addr;
		int n;
		int we_before;
		int pulses_before;
		int assert_fails;
		CLK_MASTER = 1'b0;
		rst = 1'b1;
		mcu_pmall = 1'b0;
		mcu_pmwr = 1'b0;
		mcu_pmrd = 1'b0;
		mcu_pmd_in = '0;
		fd_index_in = 1'b0;
		fd_track0_in = 1'b1;					// Head away from track 0
		fd_wrprot_in = 1'b1;
		fd_rdy_dchg_in = 1'b0;
		fd_dens_in = 1'b1;
		for (int i = 0; i < (1 << SRAM_ADDR_W); i++) begin
			sram_mem[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16) ^ 8'h5A);
		end
		repeat (10) @(posedge CLK_MASTER);
		rst <= 1'b0;
		@(posedge CLK_MASTER);

		// Reset state
		check({fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out}, 8'hFF, "drive outputs");
		check({sram_we_n, sram_oe_n, fd_step}, 3'b100, "SRAM strobes and step");
		read_check(REG_STATUS2, {fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in,
			fd_dens_in, 3'b010}, "STATUS2 after reset");

		// Identity and bus test
		read_check(REG_DRIVE_CONTROL, MCO_TYPE[7:0], "type low");
		read_check(REG_MCO_TYPE_H, MCO_TYPE[15:8], "type high");
		read_check(REG_MCO_VER_L, MCO_VERSION[7:0], "version low");
		read_check(REG_MCO_VER_H, MCO_VERSION[15:8], "version high");
		d = byte_t'(rand_bits(8));
		bus_write(REG_SCRATCH, d);
		read_check(REG_SCRATCH, d, "scratchpad");
		read_check(REG_SCRATCH_INV, ~d, "inverse scratchpad");
		read_check(REG_FIXED_55, 8'h55, "fixed 55");
		read_check(REG_FIXED_AA, 8'hAA, "fixed AA");
		read_check(8'h40, 8'h00, "unmapped register");

		// Drive control lines are active low
		d = byte_t'(rand_bits(8));
		bus_write(REG_DRIVE_CONTROL, d);
		check({fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out}, byte_t'(~d),
			"drive lines");

		// Address load and SRAM writes
		exp_addr = SRAM_ADDR_W'(rand_bits(SRAM_ADDR_W)) & 19'h3FFFF;	// Keep clear of full
		load_address(exp_addr, 5'(rand_bits(5)));
		check_address(exp_addr, "loaded address");
		repeat (4) begin
			d = byte_t'(rand_bits(8));
			we_before = we_low_cycles;
			bus_write(REG_SRAM_DATA, d);
			check(we_low_cycles - we_before, 1, "WE low cycles per write");
			check(sram_mem[exp_addr], d, "SRAM byte written");
			exp_addr++;
			check_address(exp_addr, "address after write");
		end

		// SRAM reads advance the address
		exp_addr = SRAM_ADDR_W'(rand_bits(SRAM_ADDR_W)) & 19'h3FFFF;
		load_address(exp_addr, 5'b0);
		repeat (2) begin
			read_check(REG_SRAM_DATA, sram_mem[exp_addr], "SRAM read data");
			exp_addr++;
			check_address(exp_addr, "address after read");
		end
		load_address('1, 5'b0);
		bus_read(REG_STATUS2, rd);
		check(rd[1:0], 2'b01, "full flag at all ones");
		read_check(REG_SRAM_DATA, sram_mem[(1 << SRAM_ADDR_W) - 1], "SRAM read at top");
		check_address('1, "saturated address");

		// Inward stepping
		bus_write(REG_STEP_RATE, byte_t'(STEP_RATE));
		n = int'(rand_bits(4)) + 1;
		pulses_before = step_pulses;
		bus_write(REG_STEP_CMD, byte_t'(8'h80 | n));
		check({fd_dir, stepping_now()}, 2'b11, "direction and stepping after load");
		wait_step_done();
		check(step_pulses - pulses_before, n, "inward step pulses");

		// Outward with track 0 already active
		@(posedge CLK_MASTER);
		fd_track0_in <= 1'b0;
		pulses_before = step_pulses;
		bus_write(REG_STEP_CMD, byte_t'(n));
		wait_step_done();
		check(step_pulses - pulses_before, 0, "outward pulses at track 0");
		check(stepping_now(), 1'b0, "stepping after track 0 stop");

		repeat (4) @(posedge CLK_MASTER);
		assert_fails = i_fdc_top.i_fdc_asserts.fail_count;
		$display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, assert_fails);
		if (mismatches + failures + assert_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/fdc_pkg.sv
verilog/mcu_register_file.sv
verilog/sram_address_counter.sv
verilog/sram_write_sequencer.sv
verilog/head_stepper.sv
verilog/fdc_top.sv
verification/fdc_asserts.sv
verification/fdc_tb.sv

// ==== Bender.yml ====
package:
  name: fdc_mcu_if

sources:
  - verilog/fdc_pkg.sv
  - verilog/mcu_register_file.sv
  - verilog/sram_address_counter.sv
  - verilog/sram_write_sequencer.sv
  - verilog/head_stepper.sv
  - verilog/fdc_top.sv
  - target: simulation
    files:
      - verification/fdc_asserts.sv
      - verification/fdc_tb.sv
